//--- tb.f
rtl/rv_isa_pkg.sv
rtl/bru_cfg_pkg.sv
rtl/ras_if.sv
rtl/branch_comparator.sv
rtl/branch_unit.sv
rtl/return_stack.sv
rtl/branch_exec_top.sv
dv/branch_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the branch execution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module branch_exec_tb \
    -f tb.f -o branch_exec_sim

sim_out=$(./obj_dir/branch_exec_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

//--- dv/branch_exec_tb.sv
// Testbench for the branch execution slice with reference model, random stimulus and assertions
`default_nettype none
`timescale 1ns/10ps

module branch_exec_tb;
    import rv_isa_pkg::*;
    import bru_cfg_pkg::*;

    localparam int num_random  = 400;
    // Sweep, ten calls, ten returns and one linking jalr
    localparam int num_ops     = 39 + num_random;
    // At most five cycles per operation plus reset and drain
    localparam int cycle_limit = num_ops * 5 + 50;

    logic   clk;
    logic   rst;
    logic   new_request;
    instr_t instruction;
    addr_t  pc;
    word_t  rs1_data;
    word_t  rs2_data;
    addr_t  dec_pc;
    logic   dec_pc_valid;
    logic   branch_ex;
    logic   branch_taken;
    logic   flush;
    addr_t  jump_pc;
    addr_t  njump_pc;
    addr_t  redirect_pc;
    addr_t  ras_addr;
    logic   ras_valid;
    logic   tr_correct;
    logic   tr_mispredict;
    logic   tr_return_mispredict;

    logic [31:0] seed;
    int          issued;
    int          ex_count;
    int          cycles;
    logic        tb_held;
    addr_t       cur_redirect;

    // Reference model of the held branch and the stack with the top at index 0
    logic  m_held;
    logic  m_taken;
    logic  m_call;
    logic  m_ret;
    addr_t m_target;
    addr_t m_fall;
    addr_t m_stack [ras_depth_default];
    int    m_count;
    logic  m_completing;
    logic  exp_mis;
    addr_t exp_redirect;

    branch_exec_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and instruction building

    function automatic logic [31:0] next_random();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_random() % 32'(n));
    endfunction

    // Link registers favoured so calls and returns come up often
    function automatic reg_idx_t pick_reg();
        case (rand_below(4))
            0: return reg_ra;
            1: return reg_t0;
            2: return 5'd0;
            default: return reg_idx_t'(next_random());
        endcase
    endfunction

    // Kinds 0 to 5 are the six branches, 6 jal, 7 jalr, 8 to 10 fixed link forms
    function automatic instr_t make_instr(input int kind);
        word_t bits;
        bits = next_random();
        case (kind)
            0: return {bits[31:15], fn3_beq, bits[11:7], opc_branch};
            1: return {bits[31:15], fn3_bne, bits[11:7], opc_branch};
            2: return {bits[31:15], fn3_blt, bits[11:7], opc_branch};
            3: return {bits[31:15], fn3_bge, bits[11:7], opc_branch};
            4: return {bits[31:15], fn3_bltu, bits[11:7], opc_branch};
            5: return {bits[31:15], fn3_bgeu, bits[11:7], opc_branch};
            6: return {bits[31:12], pick_reg(), opc_jal};
            7: return {bits[31:20], pick_reg(), 3'b000, pick_reg(), opc_jalr};
            8: return {bits[31:12], reg_ra, opc_jal};
            9: return {bits[31:20], reg_ra, 3'b000, 5'd0, opc_jalr};
            default: return {bits[31:20], reg_ra, 3'b000, reg_t0, opc_jalr};
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ISA rules

    function automatic logic expect_taken(input instr_t i, input word_t a, input word_t b);
        // Jumps always go
        if (i[6:0] != opc_branch) begin
            return 1'b1;
        end
        case (i[14:12])
            fn3_beq:  return a == b;
            fn3_bne:  return a != b;
            fn3_blt:  return $signed(a) < $signed(b);
            fn3_bge:  return $signed(a) >= $signed(b);
            fn3_bltu: return a < b;
            default:  return a >= b;
        endcase
    endfunction

    function automatic addr_t expect_target(input instr_t i, input addr_t p, input word_t a);
        word_t imm;
        addr_t sum;
        case (i[6:0])
            opc_jal:  imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            opc_jalr: imm = {{20{i[31]}}, i[31:20]};
            default:  imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        endcase
        sum = ((i[6:0] == opc_jalr) ? a : p) + imm;
        return {sum[31:1], 1'b0};
    endfunction

    function automatic logic is_link(input reg_idx_t r);
        return (r == reg_ra) || (r == reg_t0);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Model

    assign m_completing = m_held & dec_pc_valid;
    assign exp_redirect = m_taken ? m_target : m_fall;
    assign exp_mis      = (dec_pc[31:1] != exp_redirect[31:1]);

    always @(posedge clk) begin
        if (rst) begin
            m_held  <= 1'b0;
            m_count <= 0;
        end else begin
            if (m_completing && m_call && m_ret) begin
                // Both at once swaps the top entry
                m_stack[0] <= m_fall;
            end else if (m_completing && m_call) begin
                for (int k = ras_depth_default - 1; k > 0; k--) begin
                    m_stack[k] <= m_stack[k - 1];
                end
                m_stack[0] <= m_fall;
                if (m_count < ras_depth_default) begin
                    m_count <= m_count + 1;
                end
            end else if (m_completing && m_ret && m_count != 0) begin
                for (int k = 0; k < ras_depth_default - 1; k++) begin
                    m_stack[k] <= m_stack[k + 1];
                end
                m_count <= m_count - 1;
            end
            if (new_request) begin
                m_held   <= 1'b1;
                m_taken  <= expect_taken(instruction, rs1_data, rs2_data);
                m_target <= expect_target(instruction, pc, rs1_data);
                m_fall   <= pc + 32'd4;
                m_call   <= (instruction[6:0] == opc_jal || instruction[6:0] == opc_jalr)
                            && is_link(instruction[11:7]);
                m_ret    <= (instruction[6:0] == opc_jalr) && is_link(instruction[19:15])
                            && !is_link(instruction[11:7]);
            end else if (dec_pc_valid) begin
                m_held <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ex_count <= 0;
        end else if (branch_ex) begin
            ex_count <= ex_count + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        stop_with_failure($sformatf("** Error: %s expected %h got %h", name, exp_val, got_val));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks

    chk_branch_ex: assert property (@(posedge clk) disable iff (rst) branch_ex == m_completing)
        else report_mismatch("branch_ex", 32'($sampled(m_completing)), 32'($sampled(branch_ex)));
    chk_taken: assert property (@(posedge clk) disable iff (rst)
        !m_completing || branch_taken == m_taken)
        else report_mismatch("branch_taken", 32'($sampled(m_taken)), 32'($sampled(branch_taken)));
    chk_jump_pc: assert property (@(posedge clk) disable iff (rst)
        !m_completing || jump_pc == m_target)
        else report_mismatch("jump_pc", $sampled(m_target), $sampled(jump_pc));
    chk_njump_pc: assert property (@(posedge clk) disable iff (rst)
        !m_completing || njump_pc == m_fall)
        else report_mismatch("njump_pc", $sampled(m_fall), $sampled(njump_pc));
    chk_redirect: assert property (@(posedge clk) disable iff (rst)
        !m_completing || redirect_pc == exp_redirect)
        else report_mismatch("redirect_pc", $sampled(exp_redirect), $sampled(redirect_pc));
    chk_flush: assert property (@(posedge clk) disable iff (rst)
        flush == (m_completing && exp_mis))
        else report_mismatch("flush", 32'($sampled(m_completing && exp_mis)),
                             32'($sampled(flush)));
    chk_tr_correct: assert property (@(posedge clk) disable iff (rst)
        tr_correct == (m_completing && !m_ret && !exp_mis))
        else report_mismatch("tr_correct", 32'($sampled(m_completing && !m_ret && !exp_mis)),
                             32'($sampled(tr_correct)));
    chk_tr_mispredict: assert property (@(posedge clk) disable iff (rst)
        tr_mispredict == (m_completing && !m_ret && exp_mis))
        else report_mismatch("tr_mispredict", 32'($sampled(m_completing && !m_ret && exp_mis)),
                             32'($sampled(tr_mispredict)));
    chk_tr_return: assert property (@(posedge clk) disable iff (rst)
        tr_return_mispredict == (m_completing && m_ret && exp_mis))
        else report_mismatch("tr_return_mispredict",
                             32'($sampled(m_completing && m_ret && exp_mis)),
                             32'($sampled(tr_return_mispredict)));
    chk_ras_valid: assert property (@(posedge clk) disable iff (rst)
        ras_valid == (m_count != 0))
        else report_mismatch("ras_valid", 32'($sampled(m_count != 0)), 32'($sampled(ras_valid)));
    chk_ras_addr: assert property (@(posedge clk) disable iff (rst)
        m_count == 0 || ras_addr == m_stack[0])
        else report_mismatch("ras_addr", $sampled(m_stack[0]), $sampled(ras_addr));

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    // Right next PC, right with bit 0 set, or a wrong one
    function automatic addr_t pick_dec_pc(input addr_t r);
        logic [31:0] wrong;
        wrong = next_random();
        case (rand_below(3))
            0: return r;
            1: return r | 32'd1;
            default: return r + {wrong[31:3], 3'b100};
        endcase
    endfunction

    task automatic complete_held();
        @(negedge clk);
        new_request  = 1'b0;
        dec_pc_valid = 1'b1;
        dec_pc       = pick_dec_pc(cur_redirect);
        tb_held      = 1'b0;
    endtask

    // Operand class 0 equal, 1 sign bit apart, 2 random
    task automatic run_op(input instr_t instr, input int op_class);
        word_t a;
        word_t b;
        addr_t op_pc;
        int    hold;
        a     = next_random();
        b     = (op_class == 0) ? a : (op_class == 1) ? (a ^ 32'h8000_0000) : next_random();
        op_pc = next_random() & 32'hffff_fffc;
        hold  = rand_below(4);
        @(negedge clk);
        // Back to back when the previous branch is still held
        if (tb_held) begin
            dec_pc_valid = 1'b1;
            dec_pc       = pick_dec_pc(cur_redirect);
        end else begin
            dec_pc_valid = next_random() > 32'h8000_0000;
            dec_pc       = next_random();
        end
        new_request  = 1'b1;
        instruction  = instr;
        pc           = op_pc;
        rs1_data     = a;
        rs2_data     = b;
        cur_redirect = expect_taken(instr, a, b) ? expect_target(instr, op_pc, a) : op_pc + 32'd4;
        issued++;
        tb_held      = 1'b1;
        // Scrambled issue fields while held
        repeat (hold) begin
            @(negedge clk);
            new_request  = 1'b0;
            dec_pc_valid = 1'b0;
            instruction  = next_random();
            pc           = next_random();
            rs1_data     = next_random();
            dec_pc       = next_random();
        end
        if (rand_below(3) != 0) begin
            complete_held();
        end
    endtask

    initial begin
        seed         = 32'hac52_8bbf;
        rst          = 1'b1;
        new_request  = 1'b0;
        instruction  = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        dec_pc       = '0;
        dec_pc_valid = 1'b0;
        issued       = 0;
        tb_held      = 1'b0;
        cur_redirect = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Every branch code against every operand class
        for (int k = 0; k < 6; k++) begin
            for (int c = 0; c < 3; c++) begin
                run_op(make_instr(k), c);
            end
        end
        // Overflow, drain past empty, then the doubly linking jalr
        repeat (10) run_op(make_instr(8), 2);
        repeat (10) run_op(make_instr(9), 2);
        run_op(make_instr(10), 2);
        repeat (num_random) run_op(make_instr(rand_below(8)), rand_below(3));
        if (tb_held) begin
            complete_held();
        end
        @(negedge clk);
        new_request  = 1'b0;
        dec_pc_valid = 1'b0;
        repeat (3) @(negedge clk);
        if (ex_count == issued) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure($sformatf("branch_ex pulsed %0d times for %0d issued branches",
                                        ex_count, issued));
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_failure($sformatf("Timeout after %0d cycles without finishing", cycle_limit));
    end

endmodule

`default_nettype wire

//--- rtl/branch_exec_top.sv
// Branch execution top: branch unit and return stack joined by the RAS interface
`default_nettype none
`timescale 1ns/10ps

module branch_exec_top #(
    parameter bit use_predictor = bru_cfg_pkg::use_predictor_default,
    parameter int ras_depth     = bru_cfg_pkg::ras_depth_default,
    parameter bit enable_trace  = bru_cfg_pkg::enable_trace_default
) (
    input  logic                clk,
    input  logic                rst,

    input  logic                new_request,
    input  rv_isa_pkg::instr_t  instruction,
    input  rv_isa_pkg::addr_t   pc,
    input  rv_isa_pkg::word_t   rs1_data,
    input  rv_isa_pkg::word_t   rs2_data,

    input  rv_isa_pkg::addr_t   dec_pc,
    input  logic                dec_pc_valid,

    output logic                branch_ex,
    output logic                branch_taken,
    output logic                flush,
    output rv_isa_pkg::addr_t   jump_pc,
    output rv_isa_pkg::addr_t   njump_pc,
    output rv_isa_pkg::addr_t   redirect_pc,

    // Return prediction toward fetch
    output rv_isa_pkg::addr_t   ras_addr,
    output logic                ras_valid,

    output logic                tr_correct,
    output logic                tr_mispredict,
    output logic                tr_return_mispredict
);

    logic tr_correct_int;
    logic tr_mispredict_int;
    logic tr_return_mispredict_int;

    ras_if ras_bus ();

    branch_unit #(
        .use_predictor (use_predictor)
    ) u_branch_unit (
        .clk                  (clk),
        .rst                  (rst),
        .new_request          (new_request),
        .instruction          (instruction),
        .pc                   (pc),
        .rs1_data             (rs1_data),
        .rs2_data             (rs2_data),
        .dec_pc               (dec_pc),
        .dec_pc_valid         (dec_pc_valid),
        .branch_ex            (branch_ex),
        .branch_taken         (branch_taken),
        .flush                (flush),
        .jump_pc              (jump_pc),
        .njump_pc             (njump_pc),
        .redirect_pc          (redirect_pc),
        .ras                  (ras_bus.branch_unit),
        .tr_correct           (tr_correct_int),
        .tr_mispredict        (tr_mispredict_int),
        .tr_return_mispredict (tr_return_mispredict_int)
    );

    return_stack #(
        .ras_depth (ras_depth)
    ) u_return_stack (
        .clk (clk),
        .rst (rst),
        .ras (ras_bus.stack)
    );

    // Fetch view of the stack top
    assign ras_addr  = ras_bus.top_addr;
    assign ras_valid = ras_bus.valid;

    // Trace port, tied low when not built in
    generate
        if (enable_trace) begin : g_trace
            assign tr_correct           = tr_correct_int;
            assign tr_mispredict        = tr_mispredict_int;
            assign tr_return_mispredict = tr_return_mispredict_int;
        end else begin : g_no_trace
            assign tr_correct           = 1'b0;
            assign tr_mispredict        = 1'b0;
            assign tr_return_mispredict = 1'b0;
        end
    endgenerate

endmodule

`default_nettype wire

//--- rtl/return_stack.sv
// Circular return address stack with top pointer and saturating count
`default_nettype none
`timescale 1ns/10ps

module return_stack #(
    parameter int ras_depth = bru_cfg_pkg::ras_depth_default
) (
    input  logic    clk,
    input  logic    rst,
    ras_if.stack    ras
);
    import rv_isa_pkg::*;

    localparam int ptr_w = $clog2(ras_depth);

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [ptr_w:0]   cnt_t;

    addr_t stack_mem [ras_depth];
    ptr_t  top_ptr;
    ptr_t  next_ptr;
    cnt_t  count;
    logic  empty;
    logic  full;

    assign empty = (count == '0);
    assign full  = (count == cnt_t'(ras_depth));

    // Slot above the current top
    assign next_ptr = top_ptr + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Pointer and occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (ras.push && !ras.pop) begin
            top_ptr <= next_ptr;
            // Oldest entry is overwritten once full
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (ras.pop && !ras.push && !empty) begin
            top_ptr <= top_ptr - 1'b1;
            count   <= count - 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Entry storage

    always_ff @(posedge clk) begin
        if (ras.push && ras.pop) begin
            // Pop and push together replace the top in place
            stack_mem[top_ptr] <= ras.new_addr;
        end else if (ras.push) begin
            stack_mem[next_ptr] <= ras.new_addr;
        end
    end

    assign ras.top_addr = stack_mem[top_ptr];
    assign ras.valid    = ~empty;

endmodule

`default_nettype wire

//--- rtl/branch_unit.sv
// Branch execution unit: decode, target compute, hold for next PC, flush, RAS and trace
`default_nettype none
`timescale 1ns/10ps

module branch_unit #(
    parameter bit use_predictor = bru_cfg_pkg::use_predictor_default
) (
    input  logic                clk,
    input  logic                rst,

    // Issue
    input  logic                new_request,
    input  rv_isa_pkg::instr_t  instruction,
    input  rv_isa_pkg::addr_t   pc,
    input  rv_isa_pkg::word_t   rs1_data,
    input  rv_isa_pkg::word_t   rs2_data,

    // PC of the instruction now in decode
    input  rv_isa_pkg::addr_t   dec_pc,
    input  logic                dec_pc_valid,

    // Resolution
    output logic                branch_ex,
    output logic                branch_taken,
    output logic                flush,
    output rv_isa_pkg::addr_t   jump_pc,
    output rv_isa_pkg::addr_t   njump_pc,
    output rv_isa_pkg::addr_t   redirect_pc,

    ras_if.branch_unit          ras,

    // Trace
    output logic                tr_correct,
    output logic                tr_mispredict,
    output logic                tr_return_mispredict
);
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    fn3_t       fn3;

    logic       is_jal;
    logic       is_jalr;
    logic       rd_link;
    logic       rs1_link;
    logic       is_call;
    logic       is_return;
    logic       cond_taken;

    logic [19:0] jal_imm;
    logic [11:0] jalr_imm;
    logic [11:0] br_imm;
    word_t       pc_offset;
    addr_t       jump_base;
    addr_t       target_sum;

    logic       branch_held;
    logic       completing;
    logic       load_en;
    logic       mispredict;

    // Holding registers
    addr_t      jump_pc_r;
    addr_t      njump_pc_r;
    logic       cond_taken_r;
    logic       jump_r;
    logic       call_r;
    logic       return_r;

    //////////////////////////////////////////////////////////////////////
    // Decode

    assign opcode = instruction[6:0];
    assign rd     = instruction[11:7];
    assign fn3    = instruction[14:12];
    assign rs1    = instruction[19:15];

    assign is_jal  = (opcode == opc_jal);
    assign is_jalr = (opcode == opc_jalr);

    // x1 and x5 are the link registers
    assign rd_link  = (rd == reg_ra) || (rd == reg_t0);
    assign rs1_link = (rs1 == reg_ra) || (rs1 == reg_t0);

    assign is_call   = (is_jal | is_jalr) & rd_link;
    assign is_return = is_jalr & rs1_link & ~rd_link;

    branch_comparator u_cmp (
        .fn3   (fn3),
        .a     (rs1_data),
        .b     (rs2_data),
        .taken (cond_taken)
    );

    //////////////////////////////////////////////////////////////////////
    // Target

    // Scrambled immediate layouts
    assign jal_imm  = {instruction[31], instruction[19:12], instruction[20], instruction[30:21]};
    assign jalr_imm = instruction[31:20];
    assign br_imm   = {instruction[31], instruction[7], instruction[30:25], instruction[11:8]};

    always_comb begin
        if (is_jalr) begin
            pc_offset = word_t'(signed'(jalr_imm));
        end else if (is_jal) begin
            pc_offset = word_t'(signed'({jal_imm, 1'b0}));
        end else begin
            pc_offset = word_t'(signed'({br_imm, 1'b0}));
        end
    end

    // Register base for jalr, own PC otherwise
    assign jump_base  = is_jalr ? rs1_data : pc;
    assign target_sum = jump_base + pc_offset;

    //////////////////////////////////////////////////////////////////////
    // Hold until the next instruction reaches decode

    always_ff @(posedge clk) begin
        if (rst) begin
            branch_held <= 1'b0;
        end else if (new_request) begin
            branch_held <= 1'b1;
        end else if (dec_pc_valid) begin
            branch_held <= 1'b0;
        end
    end

    assign completing = branch_held & dec_pc_valid;

    // Free to capture when nothing is held or the held branch leaves now
    assign load_en = ~branch_held | completing;

    always_ff @(posedge clk) begin
        if (load_en) begin
            jump_pc_r    <= {target_sum[31:1], 1'b0};
            njump_pc_r   <= pc + 32'd4;
            cond_taken_r <= cond_taken;
            jump_r       <= is_jal | is_jalr;
            call_r       <= is_call;
            return_r     <= is_return;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Resolution

    // Valid alongside branch_ex
    assign branch_taken = jump_r | cond_taken_r;
    assign jump_pc      = jump_pc_r;
    assign njump_pc     = njump_pc_r;
    assign redirect_pc  = branch_taken ? jump_pc_r : njump_pc_r;
    assign branch_ex    = completing;

    // Bit 0 is not part of a fetch address
    assign mispredict = (dec_pc[31:1] != redirect_pc[31:1]);

    assign flush = completing & (use_predictor ? mispredict : branch_taken);

    // Stack update
    assign ras.push     = completing & call_r;
    assign ras.pop      = completing & return_r;
    assign ras.new_addr = njump_pc_r;

    //////////////////////////////////////////////////////////////////////
    // Trace

    assign tr_correct           = completing & ~return_r & ~mispredict;
    assign tr_mispredict        = completing & ~return_r & mispredict;
    assign tr_return_mispredict = completing & return_r & mispredict;

endmodule

`default_nettype wire

//--- rtl/branch_comparator.sv
// Conditional branch comparator for the six RV32I branch conditions
`default_nettype none
`timescale 1ns/10ps

module branch_comparator (
    input  rv_isa_pkg::fn3_t  fn3,
    input  rv_isa_pkg::word_t a,
    input  rv_isa_pkg::word_t b,
    output logic              taken
);
    import rv_isa_pkg::*;

    logic use_signed;
    logic use_less_than;
    logic less_than;
    logic equal;
    logic raw_result;

    // Compare kind from funct3
    always_comb begin
        case (fn3)
            fn3_blt, fn3_bge: begin
                use_signed    = 1'b1;
                use_less_than = 1'b1;
            end
            fn3_bltu, fn3_bgeu: begin
                use_signed    = 1'b0;
                use_less_than = 1'b1;
            end
            default: begin
                use_signed    = 1'b0;
                use_less_than = 1'b0;
            end
        endcase
    end

    // One 33-bit signed compare covers both signed and unsigned cases
    assign less_than = signed'({use_signed & a[31], a}) < signed'({use_signed & b[31], b});
    assign equal     = (a == b);

    assign raw_result = use_less_than ? less_than : equal;

    // Odd codes are the negated forms (bne, bge, bgeu)
    assign taken = raw_result ^ fn3[0];

endmodule

`default_nettype wire

//--- rtl/ras_if.sv
// Return address stack interface with branch unit, stack and fetch modports
`default_nettype none
`timescale 1ns/10ps

interface ras_if;
    import rv_isa_pkg::*;

    // Stack updates from branch resolution
    logic  push;
    logic  pop;
    addr_t new_addr;

    // Stack top toward fetch
    addr_t top_addr;
    logic  valid;

    // Resolving side
    modport branch_unit (output push, pop, new_addr);

    // Storage side
    modport stack (input push, pop, new_addr, output top_addr, valid);

    // Prediction consumer
    modport fetch (input top_addr, valid);

endinterface

`default_nettype wire

//--- rtl/bru_cfg_pkg.sv
// Default parameter values for the branch execution slice
`default_nettype none

package bru_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Return address stack

    // Entry count, power of two so the pointer wraps on its own
    localparam int ras_depth_default = 8;

    //////////////////////////////////////////////////////////////////////
    // Flush policy

    // Set: fetch is predicting, so flush only when the next PC is wrong
    // Clear: fetch always falls through, so flush on every taken branch
    localparam bit use_predictor_default = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Trace

    // Per-branch classification pulses toward the trace port
    localparam bit enable_trace_default = 1'b1;

endpackage

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
// RV32I word, address, instruction and field types; opcode, funct3 and link register encodings
`default_nettype none

package rv_isa_pkg;

    // Basic vector types
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  fn3_t;

    //////////////////////////////////////////////////////////////////////
    // Opcodes for control transfer
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    //////////////////////////////////////////////////////////////////////
    // Conditional branch funct3 codes
    // Bit 0 inverts, bit 2 selects less-than, bit 1 selects unsigned
    localparam fn3_t fn3_beq  = 3'b000;
    localparam fn3_t fn3_bne  = 3'b001;
    localparam fn3_t fn3_blt  = 3'b100;
    localparam fn3_t fn3_bge  = 3'b101;
    localparam fn3_t fn3_bltu = 3'b110;
    localparam fn3_t fn3_bgeu = 3'b111;

    // Link registers, as used by the call and return hints
    localparam reg_idx_t reg_ra = 5'd1;
    localparam reg_idx_t reg_t0 = 5'd5;

endpackage

`default_nettype wire
